//--- sim/tb_book_table.sv
// Sorted price-level table testbench
// Queue model against the DUT, checked by assertions
module tb_book_table;
  import book_pkg::*;

  localparam bit P_IS_BID = 1'b1;
  localparam int N_DIRECTED = 32;
  localparam int N_RANDOM = 400;

  logic clk = 1'b0;
  logic reset;
  logic cmd_vld;
  cmd_t cmd;
  key_t key;
  volume_t volume;
  listsize_t list_size;
  logic notify_vld;
  key_t notify_key;
  volume_t notify_volume;

  // Model of the book, index 0 holds the best key
  key_t mkeys[$];
  volume_t mvols[$];
  // Predicted outputs after the next rising edge
  listsize_t exp_size;
  logic exp_nvld;
  key_t exp_key;
  volume_t exp_vol;
  logic check_en;

  book_table #(.P_IS_BID(P_IS_BID)) u_book_table (
    .clk             (clk),
    .i_reset         (reset),
    .i_cmd_vld       (cmd_vld),
    .i_cmd           (cmd),
    .i_key           (key),
    .i_volume        (volume),
    .o_list_size     (list_size),
    .o_notify_vld    (notify_vld),
    .o_notify_key    (notify_key),
    .o_notify_volume (notify_volume)
  );

  always #50 clk = ~clk;

  task automatic stop_on_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
    $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  // Outputs settle at the rising edge, so compare at the falling edge
  // Notify pair tracks the top entry on every cycle, pulse or not
  size_check: assert property (@(negedge clk) !check_en || (list_size == exp_size))
    else stop_on_mismatch("o_list_size", $sampled(list_size), $sampled(exp_size));
  nvld_check: assert property (@(negedge clk) !check_en || (notify_vld == exp_nvld))
    else stop_on_mismatch("o_notify_vld", $sampled(notify_vld), $sampled(exp_nvld));
  nkey_check: assert property (@(negedge clk) !check_en || (notify_key == exp_key))
    else stop_on_mismatch("o_notify_key", $sampled(notify_key), $sampled(exp_key));
  nvol_check: assert property (@(negedge clk) !check_en || (notify_volume == exp_vol))
    else stop_on_mismatch("o_notify_volume", $sampled(notify_volume), $sampled(exp_vol));

  // Bid side ranks higher prices first
  function automatic logic better(key_t a, key_t b);
    return P_IS_BID ? (a > b) : (a < b);
  endfunction

  function automatic int find_key(key_t k);
    int idx = -1;
    for (int i = 0; i < mkeys.size(); i++) begin
      if (mkeys[i] == k) idx = i;
    end
    return idx;
  endfunction

  // Apply one command to the model and predict the outputs
  task automatic model_step(input logic vld, input cmd_t c, input key_t k, input volume_t v);
    int pos;
    pos = 0;
    exp_nvld = 1'b0;
    if (vld) begin
      case (c)
        CMD_CLEAR: begin
          exp_nvld = (mkeys.size() > 0);
          mkeys.delete();
          mvols.delete();
        end
        CMD_ADD: begin
          while (pos < mkeys.size() && !better(k, mkeys[pos])) pos++;
          // A worst key into a full table is dropped
          if (pos < ENTRIES_N) begin
            mkeys.insert(pos, k);
            mvols.insert(pos, v);
            if (mkeys.size() > ENTRIES_N) begin
              void'(mkeys.pop_back());
              void'(mvols.pop_back());
            end
            exp_nvld = (pos == 0);
          end
        end
        CMD_DELETE: begin
          pos = find_key(k);
          if (pos >= 0) begin
            mkeys.delete(pos);
            mvols.delete(pos);
            exp_nvld = (pos == 0);
          end
        end
        default: begin
          pos = find_key(k);
          if (pos >= 0) begin
            // Same volume on the top entry is not a change
            exp_nvld = (pos == 0) && (mvols[0] != v);
            mvols[pos] = v;
          end
        end
      endcase
    end
    exp_size = listsize_t'(mkeys.size());
    exp_key = (mkeys.size() > 0) ? mkeys[0] : '0;
    exp_vol = (mkeys.size() > 0) ? mvols[0] : '0;
  endtask

  task automatic send(input cmd_t c, input key_t k, input volume_t v);
    @(negedge clk);
    cmd_vld = 1'b1;
    cmd = c;
    key = k;
    volume = v;
    model_step(1'b1, c, k, v);
  endtask

  task automatic idle();
    @(negedge clk);
    cmd_vld = 1'b0;
    model_step(1'b0, CMD_CLEAR, '0, '0);
  endtask

  // Random command mix over a narrow key range so deletes and replaces hit
  task automatic send_random();
    int r;
    key_t k;
    r = $urandom_range(0, 99);
    if (r < 8) begin
      idle();
    end else if (r < 12) begin
      send(CMD_CLEAR, '0, '0);
    end else if (r < 55) begin
      // Keys in the table are never added twice
      do k = key_t'($urandom_range(0, 63)); while (find_key(k) >= 0);
      send(CMD_ADD, k, volume_t'($urandom));
    end else begin
      if (mkeys.size() > 0 && $urandom_range(0, 3) != 0) begin
        k = mkeys[$urandom_range(0, mkeys.size() - 1)];
      end else begin
        k = key_t'($urandom_range(0, 63));
      end
      send((r < 80) ? CMD_DELETE : CMD_REPLACE, k, volume_t'($urandom));
    end
  endtask

  // Watchdog
  initial begin
    #((N_DIRECTED + N_RANDOM + 50) * 100);
    $display("ERROR: run did not finish in time");
    $display("FAIL: see errors above");
    $fatal(1);
  end

  initial begin
    void'($urandom(32'h0214_d3dd));
    reset = 1'b1;
    cmd_vld = 1'b0;
    cmd = CMD_CLEAR;
    key = '0;
    volume = '0;
    check_en = 1'b0;
    exp_size = '0;
    exp_nvld = 1'b0;
    exp_key = '0;
    exp_vol = '0;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    check_en = 1'b1;
    // Quiet after reset
    repeat (3) idle();
    // Fill in shuffled order, only new best keys notify
    send(CMD_ADD, 16'd50, 16'h0500);
    send(CMD_ADD, 16'd30, 16'h0300);
    send(CMD_ADD, 16'd70, 16'h0700);
    send(CMD_ADD, 16'd10, 16'h0100);
    send(CMD_ADD, 16'd90, 16'h0900);
    send(CMD_ADD, 16'd60, 16'h0600);
    send(CMD_ADD, 16'd20, 16'h0200);
    send(CMD_ADD, 16'd80, 16'h0800);
    // Full table, worst key dropped, then a new best pushes 10 out
    send(CMD_ADD, 16'd5, 16'h0050);
    send(CMD_ADD, 16'd100, 16'h1000);
    send(CMD_REPLACE, 16'd50, 16'h1234);
    send(CMD_REPLACE, 16'd100, 16'hbeef);
    send(CMD_REPLACE, 16'd100, 16'hbeef);
    send(CMD_DELETE, 16'd10, '0);
    send(CMD_DELETE, 16'd60, '0);
    // Peel the top until 50 shows its new volume
    send(CMD_DELETE, 16'd100, '0);
    send(CMD_DELETE, 16'd90, '0);
    send(CMD_DELETE, 16'd80, '0);
    send(CMD_DELETE, 16'd70, '0);
    send(CMD_CLEAR, '0, '0);
    send(CMD_CLEAR, '0, '0);
    repeat (N_RANDOM) send_random();
    idle();
    idle();
    @(posedge clk);
    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- sources.f
src/book_pkg.sv
src/book_cmd_if.sv
src/book_locate.sv
src/book_lane_shift.sv
src/book_store.sv
src/book_table.sv
sim/tb_book_table.sv

//--- src/book_cmd_if.sv
// Table command bundle
interface book_cmd_if;
  import book_pkg::*;

  // Command strobe, one command per cycle at most
  logic cmd_vld;
  // Opcode
  cmd_t cmd;
  // Price key the command acts on
  key_t key;
  // Volume, ignored by CLEAR and DELETE
  volume_t volume;

  // Producer side
  modport src (
    output cmd_vld, cmd, key, volume
  );

  // Consumer side
  modport dst (
    input cmd_vld, cmd, key, volume
  );

endinterface

//--- src/book_lane_shift.sv
// Table payload lane
// Next value of every entry in one field
module book_lane_shift #(
  parameter type T_LANE = logic [15:0]
) (
  input  logic [book_pkg::ENTRIES_N-1:0]    i_shift_right,
  input  logic [book_pkg::ENTRIES_N-1:0]    i_shift_left,
  input  logic [book_pkg::ENTRIES_N-1:0]    i_insert,
  input  T_LANE                             i_new,
  input  T_LANE [book_pkg::ENTRIES_N-1:0]   i_cur,
  output T_LANE [book_pkg::ENTRIES_N-1:0]   o_nxt
);
  import book_pkg::*;

  for (genvar i = 0; i < ENTRIES_N; i++) begin : g_entry
    // Neighbour values, higher index ranks better
    T_LANE from_upper;
    T_LANE from_lower;

    // Top entry has nothing above it
    // Shift right there always comes with an insert
    if (i == ENTRIES_N - 1) begin : g_top
      assign from_upper = i_cur[i];
    end else begin : g_upper
      assign from_upper = i_cur[i+1];
    end

    // Bottom entry turns invalid on a shift up, so it keeps its old value
    if (i == 0) begin : g_bottom
      assign from_lower = i_cur[i];
    end else begin : g_lower
      assign from_lower = i_cur[i-1];
    end

    // Insert wins over the shift mask that also covers it
    assign o_nxt[i] = i_insert[i]      ? i_new :
                      i_shift_right[i] ? from_upper :
                      i_shift_left[i]  ? from_lower :
                      i_cur[i];
  end

endmodule

//--- src/book_locate.sv
// Table update locator
// Command decode, key match and shift masks
module book_locate #(
  parameter bit P_IS_BID = 1'b1
) (
  book_cmd_if.dst                                    i_cmd,
  input  logic [book_pkg::ENTRIES_N-1:0]             i_cur_vld,
  input  book_pkg::key_t [book_pkg::ENTRIES_N-1:0]   i_cur_keys,
  input  book_pkg::listsize_t                        i_cur_size,
  output logic [book_pkg::ENTRIES_N-1:0]             o_shift_right,
  output logic [book_pkg::ENTRIES_N-1:0]             o_shift_left,
  output logic [book_pkg::ENTRIES_N-1:0]             o_insert_key,
  output logic [book_pkg::ENTRIES_N-1:0]             o_insert_vol,
  output logic [book_pkg::ENTRIES_N-1:0]             o_vld_nxt,
  output book_pkg::listsize_t                        o_size_nxt
);
  import book_pkg::*;

  // Decoded opcode, qualified by the strobe
  logic op_clr;
  logic op_add;
  logic op_del;
  logic op_rep;

  // One-hot position of the matching key
  logic [ENTRIES_N-1:0] match_sel;
  logic match_hit;

  // Entries that do not rank ahead of the command key
  logic [ENTRIES_N-1:0] not_better;
  logic [ENTRIES_N-1:0] add_right;
  logic [ENTRIES_N-1:0] add_ins;
  logic add_hit;
  logic [ENTRIES_N-1:0] del_left;

  // Masks after opcode gating
  logic [ENTRIES_N-1:0] mask_right;
  logic [ENTRIES_N-1:0] mask_left;
  logic [ENTRIES_N-1:0] mask_ins;
  logic list_full;

  // Inclusive mask from the highest set bit down to entry 0
  function automatic logic [ENTRIES_N-1:0] fill_down(input logic [ENTRIES_N-1:0] x);
    logic [ENTRIES_N-1:0] m;
    m[ENTRIES_N-1] = x[ENTRIES_N-1];
    for (int i = ENTRIES_N - 2; i >= 0; i--) begin
      m[i] = m[i+1] | x[i];
    end
    return m;
  endfunction

  assign op_clr = i_cmd.cmd_vld & (i_cmd.cmd == CMD_CLEAR);
  assign op_add = i_cmd.cmd_vld & (i_cmd.cmd == CMD_ADD);
  assign op_del = i_cmd.cmd_vld & (i_cmd.cmd == CMD_DELETE);
  assign op_rep = i_cmd.cmd_vld & (i_cmd.cmd == CMD_REPLACE);

  always_comb begin
    for (int i = 0; i < ENTRIES_N; i++) begin
      match_sel[i] = i_cur_vld[i] & (i_cur_keys[i] == i_cmd.key);
      // Empty slots never outrank a new key
      not_better[i] = ~i_cur_vld[i] |
                      (P_IS_BID ? (i_cur_keys[i] <= i_cmd.key) : (i_cur_keys[i] >= i_cmd.key));
    end
  end

  // Keys are unique, so at most one bit is set
  assign match_hit = |match_sel;

  // Sorted table makes not_better a run of low bits already
  assign add_right = fill_down(not_better);
  // Leading one of the run is the insertion point
  assign add_ins = add_right & ~(add_right >> 1);
  // Nothing set when the table is full and the key ranks last
  assign add_hit = |add_ins;

  // Entries from the match down move up by one
  assign del_left = fill_down(match_sel);

  assign mask_right = {ENTRIES_N{op_add}} & add_right;
  assign mask_left = {ENTRIES_N{op_del}} & del_left;
  assign mask_ins = {ENTRIES_N{op_add}} & add_ins;

  assign o_shift_right = mask_right;
  assign o_shift_left = mask_left;
  assign o_insert_key = mask_ins;
  // Volume also takes the new value at the match on REPLACE
  assign o_insert_vol = mask_ins | ({ENTRIES_N{op_rep}} & match_sel);

  // Validity moves with the payload
  always_comb begin
    if (op_clr) begin
      o_vld_nxt = '0;
    end else begin
      o_vld_nxt = (i_cur_vld & ~mask_right & ~mask_left) |
                  mask_ins |
                  (mask_right & ~mask_ins & (i_cur_vld >> 1)) |
                  (mask_left & (i_cur_vld << 1));
    end
  end

  // Bottom slot valid means every slot is valid
  assign list_full = i_cur_vld[0];

  always_comb begin
    if (op_clr) begin
      o_size_nxt = '0;
    end else if (op_add && add_hit && !list_full) begin
      o_size_nxt = i_cur_size + listsize_t'(1);
    end else if (op_del && match_hit) begin
      o_size_nxt = i_cur_size - listsize_t'(1);
    end else begin
      // Full ADD, missed DELETE, REPLACE or idle
      o_size_nxt = i_cur_size;
    end
  end

endmodule

//--- src/book_pkg.sv
// Order book price-level table
// Shared sizes and types
package book_pkg;

  // Number of price levels held by one side of the book
  localparam int ENTRIES_N = 8;

  // Field widths
  localparam int KEY_BITS = 16;
  localparam int VOLUME_BITS = 16;

  // Price key and the volume resting at that price
  typedef logic [KEY_BITS-1:0] key_t;
  typedef logic [VOLUME_BITS-1:0] volume_t;

  // Count of valid entries, must reach ENTRIES_N itself
  typedef logic [$clog2(ENTRIES_N + 1)-1:0] listsize_t;

  // Table commands
  typedef enum logic [1:0] {
    // Drop every entry
    CMD_CLEAR   = 2'd0,
    // Insert a pair at its sorted position
    CMD_ADD     = 2'd1,
    // Remove the entry holding the key
    CMD_DELETE  = 2'd2,
    // Overwrite the volume of the entry holding the key
    CMD_REPLACE = 2'd3
  } cmd_t;

endpackage

//--- src/book_store.sv
// Table state registers
// Current entries, size and top-of-book notify
module book_store (
  input  logic                                        clk,
  input  logic                                        i_reset,
  input  logic [book_pkg::ENTRIES_N-1:0]              i_vld_nxt,
  input  book_pkg::key_t [book_pkg::ENTRIES_N-1:0]    i_keys_nxt,
  input  book_pkg::volume_t [book_pkg::ENTRIES_N-1:0] i_volumes_nxt,
  input  book_pkg::listsize_t                         i_size_nxt,
  output logic [book_pkg::ENTRIES_N-1:0]              o_cur_vld,
  output book_pkg::key_t [book_pkg::ENTRIES_N-1:0]    o_cur_keys,
  output book_pkg::volume_t [book_pkg::ENTRIES_N-1:0] o_cur_volumes,
  output book_pkg::listsize_t                         o_cur_size,
  output logic                                        o_notify_vld,
  output book_pkg::key_t                              o_notify_key,
  output book_pkg::volume_t                           o_notify_volume
);
  import book_pkg::*;

  // Best entry index
  localparam int TOP = ENTRIES_N - 1;

  // Table state
  logic [ENTRIES_N-1:0] vld_r;
  key_t [ENTRIES_N-1:0] keys_r;
  volume_t [ENTRIES_N-1:0] volumes_r;
  listsize_t size_r;

  // Next top pair, zeroed when the top slot empties
  logic top_vld_nxt;
  key_t top_key_nxt;
  volume_t top_volume_nxt;
  logic top_chg;

  // Notify registers
  logic notify_vld_r;
  key_t notify_key_r;
  volume_t notify_volume_r;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      vld_r <= '0;
      size_r <= '0;
    end else begin
      vld_r <= i_vld_nxt;
      size_r <= i_size_nxt;
    end
  end

  // Lanes hold unchanged entries, so load every cycle
  always_ff @(posedge clk) begin
    keys_r <= i_keys_nxt;
    volumes_r <= i_volumes_nxt;
  end

  assign top_vld_nxt = i_vld_nxt[TOP];
  assign top_key_nxt = top_vld_nxt ? i_keys_nxt[TOP] : '0;
  assign top_volume_nxt = top_vld_nxt ? i_volumes_nxt[TOP] : '0;

  // Stale payload in an empty top slot is not a change
  assign top_chg = (top_vld_nxt != vld_r[TOP]) |
                   (top_vld_nxt & ((i_keys_nxt[TOP] != keys_r[TOP]) |
                                   (i_volumes_nxt[TOP] != volumes_r[TOP])));

  always_ff @(posedge clk) begin
    if (i_reset) begin
      notify_vld_r <= 1'b0;
      notify_key_r <= '0;
      notify_volume_r <= '0;
    end else begin
      // One-cycle pulse per top change
      notify_vld_r <= top_chg;
      notify_key_r <= top_key_nxt;
      notify_volume_r <= top_volume_nxt;
    end
  end

  assign o_cur_vld = vld_r;
  assign o_cur_keys = keys_r;
  assign o_cur_volumes = volumes_r;
  assign o_cur_size = size_r;

  assign o_notify_vld = notify_vld_r;
  assign o_notify_key = notify_key_r;
  assign o_notify_volume = notify_volume_r;

endmodule

//--- src/book_table.sv
// Sorted price-level table top
module book_table #(
  parameter bit P_IS_BID = 1'b1
) (
  input  logic                  clk,
  input  logic                  i_reset,
  input  logic                  i_cmd_vld,
  input  book_pkg::cmd_t        i_cmd,
  input  book_pkg::key_t        i_key,
  input  book_pkg::volume_t     i_volume,
  output book_pkg::listsize_t   o_list_size,
  output logic                  o_notify_vld,
  output book_pkg::key_t        o_notify_key,
  output book_pkg::volume_t     o_notify_volume
);
  import book_pkg::*;

  // Current state from the registers
  logic [ENTRIES_N-1:0] cur_vld;
  key_t [ENTRIES_N-1:0] cur_keys;
  volume_t [ENTRIES_N-1:0] cur_volumes;
  listsize_t cur_size;

  // Update masks
  logic [ENTRIES_N-1:0] shift_right;
  logic [ENTRIES_N-1:0] shift_left;
  logic [ENTRIES_N-1:0] insert_key;
  logic [ENTRIES_N-1:0] insert_vol;

  // Next state
  logic [ENTRIES_N-1:0] vld_nxt;
  key_t [ENTRIES_N-1:0] keys_nxt;
  volume_t [ENTRIES_N-1:0] volumes_nxt;
  listsize_t size_nxt;

  // Command bundle
  book_cmd_if u_cmd_if ();

  assign u_cmd_if.cmd_vld = i_cmd_vld;
  assign u_cmd_if.cmd = i_cmd;
  assign u_cmd_if.key = i_key;
  assign u_cmd_if.volume = i_volume;

  book_locate #(.P_IS_BID(P_IS_BID)) u_locate (
    .i_cmd         (u_cmd_if),
    .i_cur_vld     (cur_vld),
    .i_cur_keys    (cur_keys),
    .i_cur_size    (cur_size),
    .o_shift_right (shift_right),
    .o_shift_left  (shift_left),
    .o_insert_key  (insert_key),
    .o_insert_vol  (insert_vol),
    .o_vld_nxt     (vld_nxt),
    .o_size_nxt    (size_nxt)
  );

  book_lane_shift #(.T_LANE(key_t)) u_key_lane (
    .i_shift_right (shift_right),
    .i_shift_left  (shift_left),
    .i_insert      (insert_key),
    .i_new         (u_cmd_if.key),
    .i_cur         (cur_keys),
    .o_nxt         (keys_nxt)
  );

  book_lane_shift #(.T_LANE(volume_t)) u_vol_lane (
    .i_shift_right (shift_right),
    .i_shift_left  (shift_left),
    .i_insert      (insert_vol),
    .i_new         (u_cmd_if.volume),
    .i_cur         (cur_volumes),
    .o_nxt         (volumes_nxt)
  );

  book_store u_store (
    .clk             (clk),
    .i_reset         (i_reset),
    .i_vld_nxt       (vld_nxt),
    .i_keys_nxt      (keys_nxt),
    .i_volumes_nxt   (volumes_nxt),
    .i_size_nxt      (size_nxt),
    .o_cur_vld       (cur_vld),
    .o_cur_keys      (cur_keys),
    .o_cur_volumes   (cur_volumes),
    .o_cur_size      (cur_size),
    .o_notify_vld    (o_notify_vld),
    .o_notify_key    (o_notify_key),
    .o_notify_volume (o_notify_volume)
  );

  assign o_list_size = cur_size;

endmodule
